// ==== source/bridge_map_pkg.sv ====
/*
  Bridge map package.
  Host bridge addresses, the ROM load window and the bus widths.
*/
`default_nettype none

package bridge_map_pkg;

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // settings registers
  localparam bridge_addr_t ADDR_RESET    = 32'h0000_0000;
  localparam bridge_addr_t ADDR_SOUND    = 32'h0000_0010;
  localparam bridge_addr_t ADDR_TURBO    = 32'h0000_0100;
  localparam bridge_addr_t ADDR_CANCEL   = 32'h0000_0104;
  localparam bridge_addr_t ADDR_SUPPRESS = 32'h0000_0108;

  // upper nibble of the address selects the ROM load window
  localparam logic [3:0] ROM_WINDOW = 4'h1;

  typedef logic [12:0] rom_addr_t;
  typedef logic [11:0] rom_word_t;
  typedef logic [15:0] rom_store_t;
  localparam int ROM_DEPTH = 1 << $bits(rom_addr_t);

  localparam int AUDIO_WIDTH = 15;
  // buzzer is copied onto this many low bits
  localparam int AUDIO_SPREAD = 13;

  // shortened hold for simulation
  localparam int RESET_HOLD_CYCLES = 64;
  localparam int HOLD_CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

endpackage

`default_nettype wire

// ==== source/timebase_pkg.sv ====
/*
  Timebase package.
  Divider reload counts per turbo speed, the governor states and the
  tick counts used by the turbo and save-state logic.
*/
`default_nettype none

package timebase_pkg;

  typedef enum logic [1:0] {
    TURBO_1X   = 2'd0,
    TURBO_4X   = 2'd1,
    TURBO_50X  = 2'd2,
    TURBO_FULL = 2'd3
  } turbo_speed_t;

  typedef logic [11:0] div_count_t;

  // 117.964 MHz down to the 32.768 kHz core rate
  localparam div_count_t BASE_DIV_COUNT = 12'd3600;

  localparam div_count_t RELOAD_1X   = BASE_DIV_COUNT;
  localparam div_count_t RELOAD_4X   = div_count_t'(BASE_DIV_COUNT / 4);
  localparam div_count_t RELOAD_50X  = div_count_t'(BASE_DIV_COUNT / 50);
  // full speed is a special case, the half point is also 1
  localparam div_count_t RELOAD_FULL = 12'd1;

  // core ticks, shortened for simulation
  localparam int SUPPRESS_TICKS = 16;
  // double-rate ticks the CPU is held in reset
  localparam int SS_RESET_TICKS = 4;
  localparam int TICK_CNT_W =
    $clog2(((SUPPRESS_TICKS > SS_RESET_TICKS) ? SUPPRESS_TICKS : SS_RESET_TICKS) + 1);

  typedef enum logic [1:0] {
    GOV_IDLE,
    GOV_SUPPRESS,
    GOV_SS_RESET
  } gov_state_t;

endpackage

`default_nettype wire

// ==== source/core_settings.sv ====
/*
  Core settings.
  Host register bank on the bridge bus, the turbo speed readback, the
  external reset hold and the buzzer audio level.
*/
`timescale 1ns/1ns
`default_nettype none

module core_settings (
  input  wire                                    clk_sys_117_964,
  input  wire                                    reset_turbo_s,
  input  wire bridge_map_pkg::bridge_addr_t      bridge_addr,
  input  wire                                    bridge_wr,
  input  wire bridge_map_pkg::bridge_data_t      bridge_wr_data,
  input  wire                                    bridge_rd,
  output bridge_map_pkg::bridge_data_t           bridge_rd_data,
  input  wire                                    turbo_clear,
  input  wire                                    buzzer,
  output timebase_pkg::turbo_speed_t             turbo_speed,
  output logic                                   cancel_on_event,
  output logic                                   suppress_on_activate,
  output logic                                   external_reset,
  output logic [bridge_map_pkg::AUDIO_WIDTH-1:0] audio_level
);

  import bridge_map_pkg::*;
  import timebase_pkg::*;

  logic                  sound_disable;
  logic [HOLD_CNT_W-1:0] hold_count;

  //////////////////////////////////////////////////////////////////////
  // register writes

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      sound_disable        <= 1'b0;
      turbo_speed          <= TURBO_1X;
      cancel_on_event      <= 1'b0;
      suppress_on_activate <= 1'b0;
    end else begin
      if (bridge_wr) begin
        case (bridge_addr)
          ADDR_SOUND:    sound_disable        <= bridge_wr_data[0];
          ADDR_TURBO:    turbo_speed          <= turbo_speed_t'(bridge_wr_data[1:0]);
          ADDR_CANCEL:   cancel_on_event      <= bridge_wr_data[0];
          ADDR_SUPPRESS: suppress_on_activate <= bridge_wr_data[0];
          default: ;
        endcase
      end
      // governor cancel wins over a host write in the same cycle
      if (turbo_clear) begin
        turbo_speed <= TURBO_1X;
      end
    end
  end

  // only turbo speed reads back, everything else is zero
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      bridge_rd_data <= '0;
    end else if (bridge_rd) begin
      bridge_rd_data <= '0;
      if (bridge_addr == ADDR_TURBO) begin
        bridge_rd_data[1:0] <= turbo_speed;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // external reset hold

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      hold_count <= '0;
    end else if (bridge_wr && bridge_addr == ADDR_RESET) begin
      hold_count <= HOLD_CNT_W'(RESET_HOLD_CYCLES);
    end else if (hold_count != '0) begin
      hold_count <= hold_count - 1'b1;
    end
  end

  assign external_reset = (hold_count != '0);

  // muted when disabled or running at 50x and above
  assign audio_level = (!sound_disable && turbo_speed < TURBO_50X) ?
                       {{(AUDIO_WIDTH - AUDIO_SPREAD){1'b0}}, {AUDIO_SPREAD{buzzer}}} :
                       '0;

endmodule

`default_nettype wire

// ==== source/program_rom.sv ====
/*
  Program ROM.
  8K words loaded through the bridge ROM window with a byte swap,
  read synchronously by the CPU.
*/
`timescale 1ns/1ns
`default_nettype none

module program_rom (
  input  wire                                clk_sys_117_964,
  input  wire bridge_map_pkg::bridge_addr_t  bridge_addr,
  input  wire                                bridge_wr,
  input  wire bridge_map_pkg::bridge_data_t  bridge_wr_data,
  input  wire bridge_map_pkg::rom_addr_t     rom_addr,
  output bridge_map_pkg::rom_word_t          rom_data
);

  import bridge_map_pkg::*;

  rom_store_t rom_mem [ROM_DEPTH];

  logic       load_wr;
  rom_addr_t  load_addr;
  rom_store_t load_word;

  assign load_wr   = bridge_wr && (bridge_addr[31:28] == ROM_WINDOW);
  // bridge is byte addressed, ROM is word addressed
  assign load_addr = bridge_addr[13:1];
  // host sends big endian halfwords
  assign load_word = {bridge_wr_data[7:0], bridge_wr_data[15:8]};

  always_ff @(posedge clk_sys_117_964) begin
    if (load_wr) begin
      rom_mem[load_addr] <= load_word;
    end
  end

  // instruction is the low 12 bits of the stored word
  always_ff @(posedge clk_sys_117_964) begin
    rom_data <= rom_word_t'(rom_mem[rom_addr]);
  end

endmodule

`default_nettype wire

// ==== source/clock_enable_divider.sv ====
/*
  Clock enable divider.
  Down counter that makes the core tick and the double-rate tick,
  scaled by the turbo speed and frozen during a save-state halt.
*/
`timescale 1ns/1ns
`default_nettype none

module clock_enable_divider (
  input  wire                              clk_sys_117_964,
  input  wire                              reset_turbo_s,
  input  wire timebase_pkg::turbo_speed_t  turbo_speed,
  input  wire                              ss_halt,
  output logic                             clk_en_core,
  output logic                             clk_en_2x
);

  import timebase_pkg::*;

  div_count_t reload;
  div_count_t div_count;
  div_count_t half_point;

  always_comb begin
    case (turbo_speed)
      TURBO_1X:   reload = RELOAD_1X;
      TURBO_4X:   reload = RELOAD_4X;
      TURBO_50X:  reload = RELOAD_50X;
      TURBO_FULL: reload = RELOAD_FULL;
      default:    reload = RELOAD_1X;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // counter

  // half point is latched at each zero so a speed change mid period
  // cannot skip or double a 2x tick
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      div_count  <= RELOAD_1X;
      half_point <= RELOAD_1X >> 1;
    end else if (!ss_halt) begin
      if (div_count == '0) begin
        div_count  <= reload;
        half_point <= (reload == RELOAD_FULL) ? RELOAD_FULL : (reload >> 1);
      end else begin
        div_count <= div_count - 1'b1;
      end
    end
  end

  // both ticks at the zero count, 2x also at the half point
  assign clk_en_core = !ss_halt && (div_count == '0);
  assign clk_en_2x   = !ss_halt && (div_count == '0 || div_count == half_point);

endmodule

`default_nettype wire

// ==== source/turbo_control.sv ====
/*
  Turbo control.
  Governor FSM that cancels turbo on buzzer or halt, holds off the cancel
  for a window after turbo is switched on, and sequences the save-state
  reset of the CPU.
*/
`timescale 1ns/1ns
`default_nettype none

module turbo_control (
  input  wire                              clk_sys_117_964,
  input  wire                              reset_turbo_s,
  input  wire timebase_pkg::turbo_speed_t  turbo_speed,
  input  wire                              cancel_on_event,
  input  wire                              suppress_on_activate,
  input  wire                              buzzer,
  input  wire                              ss_halt,
  input  wire                              ss_begin_reset,
  input  wire                              external_reset,
  input  wire                              clk_en_core,
  input  wire                              clk_en_2x,
  output logic                             turbo_clear,
  output logic                             cpu_reset
);

  import timebase_pkg::*;

  gov_state_t            state;
  gov_state_t            state_next;
  logic [TICK_CNT_W-1:0] tick_count;
  logic [TICK_CNT_W-1:0] tick_count_next;
  logic                  prev_speed_1x;
  logic                  activate;
  logic                  in_window;

  // turbo newly switched on with suppression requested
  assign activate = suppress_on_activate && prev_speed_1x && (turbo_speed != TURBO_1X);

  //////////////////////////////////////////////////////////////////////
  // governor FSM

  always_comb begin
    state_next      = state;
    tick_count_next = tick_count;
    if (ss_begin_reset) begin
      state_next      = GOV_SS_RESET;
      tick_count_next = TICK_CNT_W'(SS_RESET_TICKS);
    end else begin
      case (state)
        GOV_IDLE: begin
          if (activate) begin
            state_next      = GOV_SUPPRESS;
            tick_count_next = TICK_CNT_W'(SUPPRESS_TICKS);
          end
        end
        GOV_SUPPRESS: begin
          if (activate) begin
            tick_count_next = TICK_CNT_W'(SUPPRESS_TICKS);
          end else if (clk_en_core) begin
            // window counts in core time
            tick_count_next = tick_count - 1'b1;
            if (tick_count == TICK_CNT_W'(1)) begin
              state_next = GOV_IDLE;
            end
          end
        end
        GOV_SS_RESET: begin
          if (clk_en_2x) begin
            tick_count_next = tick_count - 1'b1;
            if (tick_count == TICK_CNT_W'(1)) begin
              state_next = GOV_IDLE;
            end
          end
        end
        default: state_next = GOV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      state         <= GOV_IDLE;
      tick_count    <= '0;
      prev_speed_1x <= 1'b1;
    end else begin
      state         <= state_next;
      tick_count    <= tick_count_next;
      prev_speed_1x <= (turbo_speed == TURBO_1X);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs

  // the activation cycle itself already counts as inside the window
  assign in_window = (state == GOV_SUPPRESS) || (state_next == GOV_SUPPRESS);

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      turbo_clear <= 1'b0;
    end else begin
      turbo_clear <= ss_halt || (cancel_on_event && buzzer && !in_window);
    end
  end

  assign cpu_reset = (state == GOV_SS_RESET) || external_reset;

endmodule

`default_nettype wire

// ==== source/tama_support_top.sv ====
/*
  Virtual-pet support top.
  Settings bank, program ROM, clock enable divider and turbo control
  around the CPU core.
*/
`timescale 1ns/1ns
`default_nettype none

module tama_support_top (
  input  wire                                    clk_sys_117_964,
  input  wire                                    reset_turbo_s,
  // bridge bus
  input  wire bridge_map_pkg::bridge_addr_t      bridge_addr,
  input  wire                                    bridge_wr,
  input  wire bridge_map_pkg::bridge_data_t      bridge_wr_data,
  input  wire                                    bridge_rd,
  output wire bridge_map_pkg::bridge_data_t      bridge_rd_data,
  // CPU side
  input  wire                                    buzzer,
  input  wire bridge_map_pkg::rom_addr_t         rom_addr,
  output wire bridge_map_pkg::rom_word_t         rom_data,
  // save-state controller
  input  wire                                    ss_halt,
  input  wire                                    ss_begin_reset,
  output wire                                    clk_en_core,
  output wire                                    clk_en_2x,
  output wire                                    cpu_reset,
  output wire [bridge_map_pkg::AUDIO_WIDTH-1:0]  audio_level
);

  wire timebase_pkg::turbo_speed_t turbo_speed;
  wire                             cancel_on_event;
  wire                             suppress_on_activate;
  wire                             external_reset;
  wire                             turbo_clear;

  core_settings i_core_settings (
    .clk_sys_117_964      (clk_sys_117_964),
    .reset_turbo_s        (reset_turbo_s),
    .bridge_addr          (bridge_addr),
    .bridge_wr            (bridge_wr),
    .bridge_wr_data       (bridge_wr_data),
    .bridge_rd            (bridge_rd),
    .bridge_rd_data       (bridge_rd_data),
    .turbo_clear          (turbo_clear),
    .buzzer               (buzzer),
    .turbo_speed          (turbo_speed),
    .cancel_on_event      (cancel_on_event),
    .suppress_on_activate (suppress_on_activate),
    .external_reset       (external_reset),
    .audio_level          (audio_level)
  );

  program_rom i_program_rom (
    .clk_sys_117_964 (clk_sys_117_964),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .rom_addr        (rom_addr),
    .rom_data        (rom_data)
  );

  clock_enable_divider i_clock_enable_divider (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .turbo_speed     (turbo_speed),
    .ss_halt         (ss_halt),
    .clk_en_core     (clk_en_core),
    .clk_en_2x       (clk_en_2x)
  );

  turbo_control i_turbo_control (
    .clk_sys_117_964      (clk_sys_117_964),
    .reset_turbo_s        (reset_turbo_s),
    .turbo_speed          (turbo_speed),
    .cancel_on_event      (cancel_on_event),
    .suppress_on_activate (suppress_on_activate),
    .buzzer               (buzzer),
    .ss_halt              (ss_halt),
    .ss_begin_reset       (ss_begin_reset),
    .external_reset       (external_reset),
    .clk_en_core          (clk_en_core),
    .clk_en_2x            (clk_en_2x),
    .turbo_clear          (turbo_clear),
    .cpu_reset            (cpu_reset)
  );

endmodule

`default_nettype wire

// ==== testbench/tama_support_asserts.sv ====
/*
  Support logic checker.
  Concurrent assertions bound into the top level. Expected values come
  from small reference trackers kept alongside the bus and tick inputs.
*/
`timescale 1ns/1ns
`default_nettype none

module tama_support_asserts (
  input wire                                    clk_sys_117_964,
  input wire                                    reset_turbo_s,
  input wire bridge_map_pkg::bridge_addr_t      bridge_addr,
  input wire                                    bridge_wr,
  input wire bridge_map_pkg::bridge_data_t      bridge_wr_data,
  input wire                                    bridge_rd,
  input wire bridge_map_pkg::bridge_data_t      bridge_rd_data,
  input wire                                    buzzer,
  input wire bridge_map_pkg::rom_addr_t         rom_addr,
  input wire bridge_map_pkg::rom_word_t         rom_data,
  input wire                                    ss_halt,
  input wire                                    ss_begin_reset,
  input wire                                    clk_en_core,
  input wire                                    clk_en_2x,
  input wire                                    cpu_reset,
  input wire [bridge_map_pkg::AUDIO_WIDTH-1:0]  audio_level,
  input wire timebase_pkg::turbo_speed_t        turbo_speed,
  input wire                                    cancel_on_event,
  input wire                                    suppress_on_activate,
  input wire                                    turbo_clear
);

  import bridge_map_pkg::*;
  import timebase_pkg::*;

  int           fail_count = 0;
  rom_store_t   shadow [ROM_DEPTH];
  logic         written [ROM_DEPTH];
  rom_store_t   exp_word;
  logic         exp_valid;
  bridge_data_t rd_exp;
  logic [1:0]   spd_exp;
  logic [1:0]   wr_exp;
  logic         sound_off;
  logic         prev_1x;
  logic         activate;
  logic         ext_wr;
  int           win_left;
  int           ss_left;
  int           ext_left;
  int           gap;
  logic         clean;
  logic [AUDIO_WIDTH-1:0] exp_audio;

  initial begin
    for (int i = 0; i < ROM_DEPTH; i++) begin
      written[i] = 1'b0;
    end
  end

  assign activate = suppress_on_activate && prev_1x && (turbo_speed != TURBO_1X);
  assign ext_wr   = bridge_wr && (bridge_addr == ADDR_RESET);
  // muted at 50x and full speed
  assign exp_audio = (sound_off || turbo_speed == TURBO_50X || turbo_speed == TURBO_FULL) ?
                     '0 : {{(AUDIO_WIDTH - AUDIO_SPREAD){1'b0}}, {AUDIO_SPREAD{buzzer}}};

  //////////////////////////////////////////////////////////////////////
  // reference trackers

  // ROM shadow stored byte swapped on load
  always @(posedge clk_sys_117_964) begin
    if (bridge_wr && bridge_addr[31:28] == ROM_WINDOW) begin
      shadow[bridge_addr[13:1]]  <= {bridge_wr_data[7:0], bridge_wr_data[15:8]};
      written[bridge_addr[13:1]] <= 1'b1;
    end
    exp_word  <= shadow[rom_addr];
    exp_valid <= written[rom_addr] && !reset_turbo_s;
  end

  always @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      rd_exp    <= '0;
      spd_exp   <= '0;
      wr_exp    <= '0;
      sound_off <= 1'b0;
      prev_1x   <= 1'b1;
      win_left  <= 0;
      ss_left   <= 0;
      ext_left  <= 0;
      gap       <= 0;
      clean     <= 1'b0;
    end else begin
      if (bridge_wr && bridge_addr == ADDR_TURBO) begin
        spd_exp <= bridge_wr_data[1:0];
      end
      // a governor cancel wins over the host write
      if (turbo_clear) begin
        spd_exp <= '0;
      end
      if (bridge_rd) begin
        rd_exp <= (bridge_addr == ADDR_TURBO) ? bridge_data_t'(spd_exp) : '0;
      end
      wr_exp  <= bridge_wr_data[1:0];
      prev_1x <= (turbo_speed == TURBO_1X);
      if (bridge_wr && bridge_addr == ADDR_SOUND) begin
        sound_off <= bridge_wr_data[0];
      end
      // suppression window in core ticks
      if (ss_begin_reset) begin
        win_left <= 0;
      end else if (activate) begin
        win_left <= SUPPRESS_TICKS;
      end else if (clk_en_core && win_left != 0) begin
        win_left <= win_left - 1;
      end
      if (ss_begin_reset) begin
        ss_left <= SS_RESET_TICKS;
      end else if (clk_en_2x && ss_left != 0) begin
        ss_left <= ss_left - 1;
      end
      if (ext_wr) begin
        ext_left <= RESET_HOLD_CYCLES;
      end else if (ext_left != 0) begin
        ext_left <= ext_left - 1;
      end
      // a period is clean if it began at 50x and ran unhalted
      if (clk_en_core) begin
        gap   <= 1;
        clean <= (turbo_speed == TURBO_50X);
      end else begin
        gap <= gap + 1;
        if (ss_halt || turbo_speed != TURBO_50X) begin
          clean <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus and ROM

  a_readback: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    bridge_rd |=> bridge_rd_data == rd_exp)
    else begin
      $error("MISMATCH bridge_rd_data exp %h got %h", rd_exp, bridge_rd_data);
      fail_count++;
    end

  a_turbo_write: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    bridge_wr && bridge_addr == ADDR_TURBO && !turbo_clear |=> turbo_speed == wr_exp)
    else begin
      $error("MISMATCH turbo_speed exp %h got %h", wr_exp, turbo_speed);
      fail_count++;
    end

  a_rom_read: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    exp_valid |-> rom_data == exp_word[11:0])
    else begin
      $error("MISMATCH rom_data exp %h got %h", exp_word[11:0], rom_data);
      fail_count++;
    end

  //////////////////////////////////////////////////////////////////////
  // ticks and turbo governor

  a_core_with_2x: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    clk_en_core |-> clk_en_2x)
    else begin
      $error("core tick without a double-rate tick");
      fail_count++;
    end

  a_halt_no_tick: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    ss_halt |-> !clk_en_core && !clk_en_2x)
    else begin
      $error("tick pulsed while the save-state halt was high");
      fail_count++;
    end

  a_spacing_50x: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    clk_en_core && clean |-> gap == 73)
    else begin
      $error("MISMATCH core_tick_gap exp %h got %h", 73, gap);
      fail_count++;
    end

  a_halt_cancel: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    ss_halt |=> ##1 turbo_speed == TURBO_1X)
    else begin
      $error("MISMATCH turbo_speed exp %h got %h", TURBO_1X, turbo_speed);
      fail_count++;
    end

  a_buzzer_cancel: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    cancel_on_event && buzzer && win_left == 0 && !activate && !ss_begin_reset
    |=> ##1 turbo_speed == TURBO_1X)
    else begin
      $error("MISMATCH turbo_speed exp %h got %h", TURBO_1X, turbo_speed);
      fail_count++;
    end

  a_window_hold: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    (win_left != 0 || activate) && !ss_halt |=> !turbo_clear)
    else begin
      $error("turbo cancelled inside the suppression window");
      fail_count++;
    end

  //////////////////////////////////////////////////////////////////////
  // resets and audio

  a_ss_start: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    ss_begin_reset |=> cpu_reset)
    else begin
      $error("cpu_reset did not rise after the save-state reset request");
      fail_count++;
    end

  a_ss_hold: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    ss_left != 0 |-> cpu_reset)
    else begin
      $error("cpu_reset released before four double-rate ticks");
      fail_count++;
    end

  a_ss_end: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    ss_left == 1 && clk_en_2x && !ss_begin_reset && ext_left <= 1 && !ext_wr
    |=> !cpu_reset)
    else begin
      $error("cpu_reset held past four double-rate ticks");
      fail_count++;
    end

  a_ext_hold: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    ext_left != 0 |-> cpu_reset)
    else begin
      $error("cpu_reset released early during the external reset hold");
      fail_count++;
    end

  a_ext_end: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    ext_left == 1 && ss_left == 0 && !ss_begin_reset && !ext_wr |=> !cpu_reset)
    else begin
      $error("cpu_reset held past the external reset hold");
      fail_count++;
    end

  a_audio: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    audio_level == exp_audio)
    else begin
      $error("MISMATCH audio_level exp %h got %h", exp_audio, audio_level);
      fail_count++;
    end

endmodule

bind tama_support_top tama_support_asserts i_asserts (
  .clk_sys_117_964      (clk_sys_117_964),
  .reset_turbo_s        (reset_turbo_s),
  .bridge_addr          (bridge_addr),
  .bridge_wr            (bridge_wr),
  .bridge_wr_data       (bridge_wr_data),
  .bridge_rd            (bridge_rd),
  .bridge_rd_data       (bridge_rd_data),
  .buzzer               (buzzer),
  .rom_addr             (rom_addr),
  .rom_data             (rom_data),
  .ss_halt              (ss_halt),
  .ss_begin_reset       (ss_begin_reset),
  .clk_en_core          (clk_en_core),
  .clk_en_2x            (clk_en_2x),
  .cpu_reset            (cpu_reset),
  .audio_level          (audio_level),
  .turbo_speed          (turbo_speed),
  .cancel_on_event      (cancel_on_event),
  .suppress_on_activate (suppress_on_activate),
  .turbo_clear          (turbo_clear)
);

`default_nettype wire

// ==== testbench/tb_tama_support.sv ====
/*
  Support logic testbench.
  Drives the bridge, CPU and save-state inputs through each behavior;
  the bound assertions do the checking.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_tama_support;

  import bridge_map_pkg::*;
  import timebase_pkg::*;

  // longest test is the 4x suppression window at about 17k cycles
  localparam int TIMEOUT_CYCLES = 40000;

  logic                   clk_sys_117_964;
  logic                   reset_turbo_s;
  bridge_addr_t           bridge_addr;
  logic                   bridge_wr;
  bridge_data_t           bridge_wr_data;
  logic                   bridge_rd;
  bridge_data_t           bridge_rd_data;
  logic                   buzzer;
  rom_addr_t              rom_addr;
  rom_word_t              rom_data;
  logic                   ss_halt;
  logic                   ss_begin_reset;
  logic                   clk_en_core;
  logic                   clk_en_2x;
  logic                   cpu_reset;
  logic [AUDIO_WIDTH-1:0] audio_level;

  int        seed;
  int        cycle_count;
  int        fails;
  rom_addr_t loaded [8];

  tama_support_top i_tama_support_top (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .bridge_rd       (bridge_rd),
    .bridge_rd_data  (bridge_rd_data),
    .buzzer          (buzzer),
    .rom_addr        (rom_addr),
    .rom_data        (rom_data),
    .ss_halt         (ss_halt),
    .ss_begin_reset  (ss_begin_reset),
    .clk_en_core     (clk_en_core),
    .clk_en_2x       (clk_en_2x),
    .cpu_reset       (cpu_reset),
    .audio_level     (audio_level)
  );

  initial begin
    clk_sys_117_964 = 1'b0;
    forever #2 clk_sys_117_964 = ~clk_sys_117_964;
  end

  initial begin
    cycle_count = 0;
  end

  always @(posedge clk_sys_117_964) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus and timing tasks

  // one cycle with inputs changing 1 ns after the edge
  task automatic step();
    @(posedge clk_sys_117_964);
    #1;
  endtask

  task automatic bus_write(input bridge_addr_t addr, input bridge_data_t data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    step();
    bridge_wr = 1'b0;
  endtask

  task automatic bus_read(input bridge_addr_t addr);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    step();
    bridge_rd = 1'b0;
    step();
  endtask

  task automatic wait_core_ticks(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      step();
      if (clk_en_core) begin
        seen++;
      end
    end
  endtask

  task automatic wait_reset_release();
    step();
    while (cpu_reset) begin
      step();
    end
  endtask

  task automatic toggle_buzzer();
    repeat (6) begin
      buzzer = ~buzzer;
      step();
    end
    buzzer = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    seed           = 32'hcfc1b7ec;
    reset_turbo_s  = 1'b1;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    bridge_rd      = 1'b0;
    buzzer         = 1'b0;
    rom_addr       = '0;
    ss_halt        = 1'b0;
    ss_begin_reset = 1'b0;
    repeat (5) @(posedge clk_sys_117_964);
    #1;
    reset_turbo_s = 1'b0;
    step();

    // register readback
    for (int v = 0; v < 4; v++) begin
      bus_write(ADDR_TURBO, bridge_data_t'(v));
      bus_read(ADDR_TURBO);
      bus_read(ADDR_SOUND);
      bus_read(ADDR_CANCEL);
    end
    bus_write(ADDR_TURBO, 32'd0);

    // ROM load at random word addresses followed by CPU reads
    for (int i = 0; i < 8; i++) begin
      loaded[i] = rom_addr_t'($random(seed));
      bus_write({ROM_WINDOW, 14'h0, loaded[i], 1'b0}, $random(seed));
    end
    for (int i = 0; i < 8; i++) begin
      rom_addr = loaded[i];
      step();
      step();
    end

    // tick spacing at 50x and a halt which also cancels turbo
    bus_write(ADDR_TURBO, 32'd2);
    wait_core_ticks(6);
    ss_halt = 1'b1;
    repeat (20) step();
    ss_halt = 1'b0;
    step();
    bus_read(ADDR_TURBO);

    // buzzer cancel with no window
    bus_write(ADDR_CANCEL, 32'd1);
    bus_write(ADDR_TURBO, 32'd1);
    repeat (4) step();
    buzzer = 1'b1;
    repeat (2) step();
    buzzer = 1'b0;
    bus_read(ADDR_TURBO);

    // suppression window at 4x with the buzzer held across it
    bus_write(ADDR_SUPPRESS, 32'd1);
    bus_write(ADDR_TURBO, 32'd1);
    buzzer = 1'b1;
    bus_read(ADDR_TURBO);
    wait_core_ticks(SUPPRESS_TICKS);
    repeat (3) step();
    buzzer = 1'b0;
    bus_read(ADDR_TURBO);
    bus_write(ADDR_CANCEL, 32'd0);
    bus_write(ADDR_SUPPRESS, 32'd0);

    // save-state reset at full speed and the external hold
    bus_write(ADDR_TURBO, 32'd3);
    ss_begin_reset = 1'b1;
    step();
    ss_begin_reset = 1'b0;
    wait_reset_release();
    bus_write(ADDR_RESET, 32'd1);
    wait_reset_release();

    // audio level across mute and speed
    bus_write(ADDR_TURBO, 32'd1);
    toggle_buzzer();
    bus_write(ADDR_SOUND, 32'd1);
    toggle_buzzer();
    bus_write(ADDR_SOUND, 32'd0);
    bus_write(ADDR_TURBO, 32'd2);
    toggle_buzzer();
    repeat (4) step();

    fails = i_tama_support_top.i_asserts.fail_count;
    $display("assertion failures: %0d, cycles: %0d", fails, cycle_count);
    if (fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/bridge_map_pkg.sv
source/timebase_pkg.sv
source/core_settings.sv
source/program_rom.sv
source/clock_enable_divider.sv
source/turbo_control.sv
source/tama_support_top.sv
testbench/tama_support_asserts.sv
testbench/tb_tama_support.sv

// ==== Makefile ====
# Verilator build for the virtual-pet support logic testbench

VERILATOR ?= verilator
TOP       ?= tb_tama_support
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= TB PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
